// ==== hw/blimp_core.sv ====
// Blimp core top level
// In-order RV32 core for ADDI, ADD and MUL with a tagged instruction
// memory port and a retire trace output

`default_nettype none

module blimp_core import blimp_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,

  // Instruction memory port
  output mem_req_t    imem_req,
  output logic        imem_req_val,
  input  wire         imem_req_rdy,
  input  mem_resp_t   imem_resp,
  input  wire         imem_resp_val,
  output logic        imem_resp_rdy,

  // Retire trace
  output inst_trace_t trace,
  output logic        trace_val
);

  //--------------------------------------------------------------------
  // Stage links
  //--------------------------------------------------------------------

  fetch_t    fetch;
  logic      fetch_val;
  logic      fetch_rdy;

  dec_inst_t issue;
  logic      issue_val;
  logic      issue_rdy;

  exec_res_t res;
  logic      res_val;

  // Register reads and scoreboard release
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      commit_val;
  reg_idx_t  commit_rd;

  inst_fetch u_fetch (
    .clk, .rst_n,
    .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .fetch, .fetch_val, .fetch_rdy
  );

  inst_decode u_decode (
    .clk, .rst_n,
    .fetch, .fetch_val, .fetch_rdy,
    .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
    .commit_val, .commit_rd,
    .issue, .issue_val, .issue_rdy
  );

  exec_unit u_exec (
    .clk, .rst_n,
    .issue, .issue_val, .issue_rdy,
    .res, .res_val
  );

  commit_regfile u_commit (
    .clk, .rst_n,
    .res, .res_val,
    .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
    .commit_val, .commit_rd,
    .trace, .trace_val
  );

endmodule

`default_nettype wire

// ==== hw/blimp_pkg.sv ====
// Blimp core shared definitions
// Widths, message structs, FSM state enums and RV32 decode constants

`default_nettype none

package blimp_pkg;

  //--------------------------------------------------------------------
  // Widths and core constants
  //--------------------------------------------------------------------

  localparam int unsigned OPAQ_BITS   = 8;
  localparam int unsigned FETCH_SLOTS = 2;
  localparam int unsigned MUL_CYCLES  = 32;

  // Slot and multiplier counter index widths
  localparam int unsigned SLOT_BITS    = $clog2(FETCH_SLOTS);
  localparam int unsigned MUL_CNT_BITS = $clog2(MUL_CYCLES);

  localparam logic [31:0] RESET_PC = 32'h0000_0200;

  // RV32 opcode, funct3 and funct7 fields
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  localparam logic [2:0] FUNCT3_ADD    = 3'b000;

  //--------------------------------------------------------------------
  // Vector types
  //--------------------------------------------------------------------

  typedef logic [31:0]           addr_t;
  typedef logic [31:0]           word_t;
  typedef logic [4:0]            reg_idx_t;
  typedef logic [OPAQ_BITS-1:0]  opaq_t;
  typedef logic [SLOT_BITS-1:0]  slot_idx_t;
  typedef logic [MUL_CNT_BITS-1:0] mul_cnt_t;

  // Execute operation select
  typedef logic [1:0] exec_op_t;
  localparam exec_op_t OP_ADD = 2'd0;
  localparam exec_op_t OP_MUL = 2'd1;
  localparam exec_op_t OP_NOP = 2'd2;

  //--------------------------------------------------------------------
  // Messages
  //--------------------------------------------------------------------

  // Instruction memory request and response
  typedef struct packed {
    opaq_t opaq;
    addr_t addr;
  } mem_req_t;

  typedef struct packed {
    opaq_t opaq;
    word_t data;
  } mem_resp_t;

  // Fetched instruction handed to decode
  typedef struct packed {
    addr_t pc;
    word_t inst;
  } fetch_t;

  // One record per retired instruction
  typedef struct packed {
    addr_t    pc;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wen;
  } inst_trace_t;

  // Decoded instruction with operands already read
  typedef struct packed {
    addr_t    pc;
    exec_op_t op;
    reg_idx_t rd;
    logic     wen;
    word_t    opa;
    word_t    opb;
  } dec_inst_t;

  typedef struct packed {
    addr_t    pc;
    reg_idx_t rd;
    logic     wen;
    word_t    result;
  } exec_res_t;

  //--------------------------------------------------------------------
  // FSM states
  //--------------------------------------------------------------------

  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT,
    SLOT_FULL
  } slot_state_t;

  typedef enum logic {
    EX_IDLE,
    EX_MUL
  } exec_state_t;

endpackage

`default_nettype wire

// ==== hw/commit_regfile.sv ====
// Commit and architectural register file
// Writes back results, bypasses same-cycle writes to the read ports
// and emits one trace record per retired instruction

`default_nettype none

module commit_regfile import blimp_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,

  // From execute
  input  exec_res_t   res,
  input  wire         res_val,

  // Read ports for decode
  input  reg_idx_t    rs1_idx,
  input  reg_idx_t    rs2_idx,
  output word_t       rs1_data,
  output word_t       rs2_data,

  // Scoreboard release
  output logic        commit_val,
  output reg_idx_t    commit_rd,

  // Retire trace
  output inst_trace_t trace,
  output logic        trace_val
);

  exec_res_t cm_q;
  logic      cm_val;
  logic      wr_en;

  // x0 is not stored
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cm_val <= 1'b0;
    end else begin
      cm_val <= res_val;
    end
  end

  always_ff @(posedge clk) begin
    if (res_val) begin
      cm_q <= res;
    end
  end

  assign wr_en = cm_val && cm_q.wen && (cm_q.rd != '0);

  //--------------------------------------------------------------------
  // Register file
  //--------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[cm_q.rd] <= cm_q.result;
    end
  end

  // Read with write-through
  function automatic word_t read_reg(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wr_en && (idx == cm_q.rd)) begin
      return cm_q.result;
    end
    return regs[idx];
  endfunction

  assign rs1_data = read_reg(rs1_idx);
  assign rs2_data = read_reg(rs2_idx);

  //--------------------------------------------------------------------
  // Commit and trace outputs
  //--------------------------------------------------------------------

  assign commit_val = cm_val;
  assign commit_rd  = cm_q.rd;

  assign trace_val = cm_val;
  assign trace     = '{pc: cm_q.pc, waddr: cm_q.rd, wdata: cm_q.result, wen: cm_q.wen};

endmodule

`default_nettype wire

// ==== hw/exec_unit.sv ====
// Execute unit
// Single-cycle adder and iterative shift-and-add multiplier that
// keeps the low word of the product

`default_nettype none

module exec_unit import blimp_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  // From decode
  input  dec_inst_t  issue,
  input  wire        issue_val,
  output logic       issue_rdy,

  // To commit
  output exec_res_t  res,
  output logic       res_val
);

  exec_state_t state;
  mul_cnt_t    cnt;

  // Multiplier datapath
  word_t acc;
  word_t mcand;
  word_t mplier;
  word_t step_sum;
  word_t add_sum;

  logic issue_fire;
  logic mul_last;

  assign issue_rdy  = (state == EX_IDLE);
  assign issue_fire = issue_val && issue_rdy;
  assign mul_last   = (state == EX_MUL) && (cnt == mul_cnt_t'(MUL_CYCLES - 1));

  assign add_sum  = issue.opa + issue.opb;
  // One partial product per cycle
  assign step_sum = acc + (mplier[0] ? mcand : '0);

  //--------------------------------------------------------------------
  // Control FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= EX_IDLE;
      cnt     <= '0;
      res_val <= 1'b0;
    end else begin
      res_val <= 1'b0;
      case (state)
        EX_IDLE: begin
          if (issue_fire) begin
            if (issue.op == OP_MUL) begin
              state <= EX_MUL;
              cnt   <= '0;
            end else begin
              res_val <= 1'b1;
            end
          end
        end
        EX_MUL: begin
          cnt <= cnt + mul_cnt_t'(1);
          if (mul_last) begin
            state   <= EX_IDLE;
            res_val <= 1'b1;
          end
        end
        default: state <= EX_IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      res.pc     <= issue.pc;
      res.rd     <= issue.rd;
      res.wen    <= issue.wen;
      // NOP yields zero, MUL result lands at the end
      res.result <= (issue.op == OP_ADD) ? add_sum : '0;
      acc        <= '0;
      mcand      <= issue.opa;
      mplier     <= issue.opb;
    end else if (state == EX_MUL) begin
      acc    <= step_sum;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      if (mul_last) begin
        res.result <= step_sum;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/inst_decode.sv ====
// Instruction decode and issue
// Decodes ADDI, ADD and MUL, reads operands and holds issue on a
// pending-destination scoreboard

`default_nettype none

module inst_decode import blimp_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  // From fetch
  input  fetch_t     fetch,
  input  wire        fetch_val,
  output logic       fetch_rdy,

  // Register file read ports
  output reg_idx_t   rs1_idx,
  output reg_idx_t   rs2_idx,
  input  word_t      rs1_data,
  input  word_t      rs2_data,

  // Commit notification
  input  wire        commit_val,
  input  reg_idx_t   commit_rd,

  // To execute
  output dec_inst_t  issue,
  output logic       issue_val,
  input  wire        issue_rdy
);

  //--------------------------------------------------------------------
  // Field decode
  //--------------------------------------------------------------------

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd_field;
  word_t      imm_i;

  logic is_addi;
  logic is_add;
  logic is_mul;
  logic uses_rs2;
  logic supported;

  assign opcode   = fetch.inst[6:0];
  assign rd_field = fetch.inst[11:7];
  assign funct3   = fetch.inst[14:12];
  assign funct7   = fetch.inst[31:25];
  // Sign-extended I-type immediate
  assign imm_i    = {{20{fetch.inst[31]}}, fetch.inst[31:20]};

  assign is_addi   = (opcode == OPC_OP_IMM) && (funct3 == FUNCT3_ADD);
  assign is_add    = (opcode == OPC_OP) && (funct3 == FUNCT3_ADD) && (funct7 == FUNCT7_BASE);
  assign is_mul    = (opcode == OPC_OP) && (funct3 == FUNCT3_ADD) && (funct7 == FUNCT7_MULDIV);
  assign uses_rs2  = is_add || is_mul;
  assign supported = is_addi || uses_rs2;

  // Unused ports read x0
  assign rs1_idx = supported ? fetch.inst[19:15] : '0;
  assign rs2_idx = uses_rs2  ? fetch.inst[24:20] : '0;

  //--------------------------------------------------------------------
  // Issue message
  //--------------------------------------------------------------------

  always_comb begin
    issue.pc  = fetch.pc;
    issue.op  = is_mul ? OP_MUL : (supported ? OP_ADD : OP_NOP);
    issue.rd  = supported ? rd_field : '0;
    // x0 destination never writes
    issue.wen = supported && (rd_field != '0);
    issue.opa = rs1_data;
    issue.opb = is_addi ? imm_i : rs2_data;
  end

  //--------------------------------------------------------------------
  // Scoreboard
  //--------------------------------------------------------------------

  logic [31:0] pending;
  logic [31:0] pending_eff;
  logic [31:0] pending_next;
  logic        hazard;
  logic        issue_fire;

  // Commit this cycle is visible through the regfile bypass
  always_comb begin
    pending_eff = pending;
    if (commit_val) begin
      pending_eff[commit_rd] = 1'b0;
    end
  end

  // Unused sources read x0, which is never pending
  assign hazard = pending_eff[rs1_idx] || pending_eff[rs2_idx] ||
                  (issue.wen && pending_eff[issue.rd]);

  assign issue_val  = fetch_val && !hazard;
  assign fetch_rdy  = issue_rdy && !hazard;
  assign issue_fire = issue_val && issue_rdy;

  always_comb begin
    pending_next = pending_eff;
    if (issue_fire && issue.wen) begin
      pending_next[issue.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/inst_fetch.sv ====
// Instruction fetch
// Keeps up to FETCH_SLOTS tagged requests outstanding, files responses
// by tag and hands instructions to decode in program order

`default_nettype none

module inst_fetch import blimp_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  // Instruction memory port
  output mem_req_t   imem_req,
  output logic       imem_req_val,
  input  wire        imem_req_rdy,
  input  mem_resp_t  imem_resp,
  input  wire        imem_resp_val,
  output logic       imem_resp_rdy,

  // To decode
  output fetch_t     fetch,
  output logic       fetch_val,
  input  wire        fetch_rdy
);

  //--------------------------------------------------------------------
  // Slot storage
  //--------------------------------------------------------------------

  slot_state_t slot_state [FETCH_SLOTS];
  addr_t       slot_pc    [FETCH_SLOTS];
  word_t       slot_inst  [FETCH_SLOTS];

  addr_t     next_pc;
  slot_idx_t head;
  slot_idx_t tail;
  slot_idx_t resp_slot;

  // Requests start the cycle after reset
  logic      run_q;

  logic req_fire;
  logic resp_fire;
  logic fetch_fire;

  // Circular increment of a slot pointer
  function automatic slot_idx_t next_slot(input slot_idx_t idx);
    if (idx == slot_idx_t'(FETCH_SLOTS - 1)) begin
      return '0;
    end
    return idx + slot_idx_t'(1);
  endfunction

  //--------------------------------------------------------------------
  // Handshakes
  //--------------------------------------------------------------------

  // Request whenever the tail slot is free, tagged with its index
  assign imem_req_val = run_q && (slot_state[tail] == SLOT_FREE);
  assign imem_req     = '{opaq: opaq_t'(tail), addr: next_pc};
  assign req_fire     = imem_req_val && imem_req_rdy;

  // Every outstanding request already owns a slot
  assign imem_resp_rdy = 1'b1;
  assign resp_slot     = imem_resp.opaq[SLOT_BITS-1:0];
  assign resp_fire     = imem_resp_val && imem_resp_rdy;

  // Head slot goes out once its data is back
  assign fetch_val  = (slot_state[head] == SLOT_FULL);
  assign fetch      = '{pc: slot_pc[head], inst: slot_inst[head]};
  assign fetch_fire = fetch_val && fetch_rdy;

  //--------------------------------------------------------------------
  // Slot state and pointers
  //--------------------------------------------------------------------

  // Request, response and fetch never touch the same slot in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FETCH_SLOTS; i++) begin
        slot_state[i] <= SLOT_FREE;
      end
      head    <= '0;
      tail    <= '0;
      next_pc <= RESET_PC;
      run_q   <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (req_fire) begin
        slot_state[tail] <= SLOT_WAIT;
        tail             <= next_slot(tail);
        next_pc          <= next_pc + 32'd4;
      end
      // Late response fills its own slot
      if (resp_fire) begin
        slot_state[resp_slot] <= SLOT_FULL;
      end
      if (fetch_fire) begin
        slot_state[head] <= SLOT_FREE;
        head             <= next_slot(head);
      end
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (req_fire) begin
      slot_pc[tail] <= next_pc;
    end
    if (resp_fire) begin
      slot_inst[resp_slot] <= imem_resp.data;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the blimp core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module blimp_tb \
  -Mdir obj_dir -f src.f || exit 1

./obj_dir/Vblimp_tb | tee /dev/stderr | grep -qx "Simulation PASSED" \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }

// ==== src.f ====
hw/blimp_pkg.sv
hw/inst_fetch.sv
hw/inst_decode.sv
hw/exec_unit.sv
hw/commit_regfile.sv
hw/blimp_core.sv
testbench/inst_mem_model.sv
testbench/blimp_tb.sv

// ==== testbench/blimp_tb.sv ====
// Blimp core testbench
// Directed ADDI, ADD, MUL and unsupported-encoding programs, then a random
// mix, each checked against a register reference model

`default_nettype none

module blimp_tb import blimp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Program lengths in instructions
  localparam int ADDI_LEN       = 6;
  localparam int ADD_LEN        = 8;
  localparam int MUL_LEN        = 10;
  localparam int RAW_LEN        = 7;
  localparam int RANDOM_LEN     = 40;
  localparam int TOTAL_LEN      = ADDI_LEN + ADD_LEN + MUL_LEN + RAW_LEN + RANDOM_LEN;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_LEN + 200;
  localparam int SEED           = 32'haf36555f;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  mem_req_t    imem_req;
  logic        imem_req_val;
  logic        imem_req_rdy;
  mem_resp_t   imem_resp;
  logic        imem_resp_val;
  logic        imem_resp_rdy;
  inst_trace_t trace;
  logic        trace_val;
  logic        req_accept;
  addr_t       req_accept_addr;

  // Reference model and expected stream
  word_t       ref_regs [32];
  word_t       prog_words [$];
  inst_trace_t exp_traces [$];
  addr_t       exp_req_addr = RESET_PC;
  int          cycle_count = 0;

  blimp_core dut (
    .clk, .rst_n,
    .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .trace, .trace_val
  );

  inst_mem_model mem (
    .clk, .rst_n,
    .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .req_accept, .req_accept_addr
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Error handling and compare tasks
  // ------------------------------------------------------------------

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_trace(input inst_trace_t got, input inst_trace_t exp);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("CHECK FAILED at %0t: trace got pc=%h waddr=%0d wdata=%h wen=%b,",
                      $time, got.pc, got.waddr, got.wdata, got.wen);
      msg = {msg, $sformatf(" expected pc=%h waddr=%0d wdata=%h wen=%b",
                            exp.pc, exp.waddr, exp.wdata, exp.wen)};
      stop_on_error(msg);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string name);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  // Requests walk up from RESET_PC one word at a time
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_req_addr = RESET_PC;
    end else if (req_accept) begin
      check_addr(req_accept_addr, exp_req_addr, "imem_req.addr");
      exp_req_addr = exp_req_addr + 32'd4;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("Timeout: run still going after %0d cycles", cycle_count));
    end
  end

  // ------------------------------------------------------------------
  // Encoding and reference model
  // ------------------------------------------------------------------

  function automatic word_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic word_t enc_rtype(input logic [6:0] funct7, input reg_idx_t rd,
                                      input reg_idx_t rs1, input reg_idx_t rs2);
    return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  // Append one instruction with its expected retire record
  task automatic push_inst(input word_t inst, input reg_idx_t rd, input word_t result,
                           input logic writes);
    inst_trace_t exp;
    exp.pc    = RESET_PC + addr_t'(4 * prog_words.size());
    exp.waddr = rd;
    exp.wdata = result;
    exp.wen   = writes && (rd != 5'd0);
    prog_words.push_back(inst);
    exp_traces.push_back(exp);
    if (exp.wen) ref_regs[rd] = result;
  endtask

  task automatic add_addi(input int rd, input int rs1, input int imm);
    logic [11:0] imm12;
    word_t       sext;
    imm12 = imm[11:0];
    sext  = {{20{imm12[11]}}, imm12};
    push_inst(enc_addi(reg_idx_t'(rd), reg_idx_t'(rs1), imm12), reg_idx_t'(rd),
              ref_regs[rs1] + sext, 1'b1);
  endtask

  task automatic add_add(input int rd, input int rs1, input int rs2);
    push_inst(enc_rtype(7'b0000000, reg_idx_t'(rd), reg_idx_t'(rs1), reg_idx_t'(rs2)),
              reg_idx_t'(rd), ref_regs[rs1] + ref_regs[rs2], 1'b1);
  endtask

  // Low word of the product
  task automatic add_mul(input int rd, input int rs1, input int rs2);
    push_inst(enc_rtype(7'b0000001, reg_idx_t'(rd), reg_idx_t'(rs1), reg_idx_t'(rs2)),
              reg_idx_t'(rd), ref_regs[rs1] * ref_regs[rs2], 1'b1);
  endtask

  // Anything else retires as an empty record
  task automatic add_raw(input word_t inst);
    push_inst(inst, 5'd0, 32'd0, 1'b0);
  endtask

  task automatic start_test(input string name);
    $display("Running %s", name);
    prog_words.delete();
    exp_traces.delete();
    foreach (ref_regs[i]) ref_regs[i] = '0;
  endtask

  // Load the program under reset, then check every retire in order
  task automatic run_program();
    inst_trace_t exp;
    @(negedge clk);
    rst_n = 1'b0;
    mem.fill_memory();
    foreach (prog_words[i]) mem.load_word(RESET_PC + addr_t'(4 * i), prog_words[i]);
    repeat (3) begin
      @(negedge clk);
      if (trace_val !== 1'b0) stop_on_error("trace_val went high during reset");
      if (imem_req_val !== 1'b0) stop_on_error("imem_req_val went high during reset");
    end
    rst_n = 1'b1;
    while (exp_traces.size() > 0) begin
      exp = exp_traces.pop_front();
      do @(negedge clk); while (trace_val !== 1'b1);
      check_trace(trace, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------

  task automatic test_addi();
    start_test("ADDI");
    add_addi(1, 0, 5);
    add_addi(2, 1, -3);
    add_addi(0, 1, 7);
    add_addi(3, 0, -2048);
    add_addi(4, 3, 2047);
    add_addi(5, 2, -1);
    run_program();
  endtask

  // Each ADD reads the result of the one before
  task automatic test_add_chain();
    start_test("ADD chain");
    add_addi(1, 0, 11);
    add_addi(2, 0, -4);
    add_add(3, 1, 2);
    add_add(4, 3, 3);
    add_add(5, 4, 1);
    add_add(4, 4, 5);
    add_add(0, 5, 5);
    add_add(6, 0, 5);
    run_program();
  endtask

  task automatic test_mul();
    start_test("MUL");
    add_addi(1, 0, -7);
    add_addi(2, 0, 13);
    add_mul(3, 1, 2);
    add_mul(4, 1, 1);
    add_addi(5, 0, 2047);
    add_mul(6, 5, 5);
    // Product overflows 32 bits
    add_mul(7, 6, 6);
    add_mul(8, 7, 1);
    add_mul(9, 7, 0);
    add_add(10, 8, 7);
    run_program();
  endtask

  // SUB and SLLI name x1 but must leave it alone
  task automatic test_unsupported();
    start_test("unsupported encodings");
    add_addi(1, 0, 9);
    add_raw(32'h4020_80b3);
    add_addi(2, 1, 1);
    add_raw(32'h0000_0000);
    add_raw(32'h0010_9093);
    add_raw(32'hffff_ffff);
    add_add(3, 1, 2);
    run_program();
  endtask

  // Small register pool keeps hazards frequent
  task automatic test_random_mix();
    word_t rnd;
    int    kind;
    int    rd;
    int    rs1;
    int    rs2;
    start_test("random mix");
    for (int i = 0; i < RANDOM_LEN; i++) begin
      kind = int'($urandom_range(0, 9));
      rnd  = $urandom();
      rd   = int'($urandom_range(0, 7));
      rs1  = int'($urandom_range(0, 7));
      rs2  = int'($urandom_range(0, 7));
      if (kind < 4) begin
        add_addi(rd, rs1, int'(rnd[11:0]));
      end else if (kind < 7) begin
        add_add(rd, rs1, rs2);
      end else if (kind < 9) begin
        add_mul(rd, rs1, rs2);
      end else begin
        add_raw({rnd[31:7], 7'b1010111});
      end
    end
    run_program();
  endtask

  initial begin
    void'($urandom(SEED));
    test_addi();
    test_add_chain();
    test_mul();
    test_unsupported();
    test_random_mix();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/inst_mem_model.sv ====
// Instruction memory model
// Stalls requests at random and answers each one after 1 to 4 cycles,
// in any order, echoing the request tag

`default_nettype none

module inst_mem_model import blimp_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  // Memory port, seen from the memory side
  input  mem_req_t   imem_req,
  input  wire        imem_req_val,
  output logic       imem_req_rdy,
  output mem_resp_t  imem_resp,
  output logic       imem_resp_val,
  input  wire        imem_resp_rdy,

  // A request is taken at the coming rising edge
  output logic       req_accept,
  output addr_t      req_accept_addr
);

  timeunit 1ns;
  timeprecision 100ps;

  word_t mem_words [1024];

  // Accepted requests still waiting for an answer
  mem_req_t pend_req   [$];
  int       pend_delay [$];
  int       ready_idx  [$];
  int       pick;

  logic      in_reset   = 1'b1;
  logic      rdy_q      = 1'b0;
  logic      resp_val_q = 1'b0;
  mem_resp_t resp_q     = '0;
  logic      acc_q      = 1'b0;
  addr_t     acc_addr_q = '0;

  assign imem_req_rdy    = rdy_q;
  assign imem_resp       = resp_q;
  assign imem_resp_val   = resp_val_q;
  assign req_accept      = acc_q;
  assign req_accept_addr = acc_addr_q;

  // Unwritten words decode as unsupported, with the word index in the upper bits
  task automatic fill_memory();
    for (int i = 0; i < 1024; i++) begin
      mem_words[i] = {10'(i), ~10'(i), 5'b10110, 7'h7f};
    end
  endtask

  task automatic load_word(input addr_t addr, input word_t data);
    mem_words[addr[11:2]] = data;
  endtask

  // Reset seen at the rising edge, so the falling-edge logic reads a stable copy
  always @(posedge clk) begin
    in_reset <= !rst_n;
  end

  always @(negedge clk) begin
    if (in_reset) begin
      pend_req.delete();
      pend_delay.delete();
      rdy_q      = 1'b0;
      resp_val_q = 1'b0;
      acc_q      = 1'b0;
    end else begin
      // Age the waiting requests
      foreach (pend_delay[i]) begin
        if (pend_delay[i] > 0) pend_delay[i]--;
      end
      ready_idx.delete();
      foreach (pend_delay[i]) begin
        if (pend_delay[i] == 0) ready_idx.push_back(i);
      end
      // Answer one ready request, picked at random
      resp_val_q = 1'b0;
      if (ready_idx.size() > 0) begin
        pick       = ready_idx[$urandom_range(0, ready_idx.size() - 1)];
        resp_q     = '{opaq: pend_req[pick].opaq, data: mem_words[pend_req[pick].addr[11:2]]};
        resp_val_q = 1'b1;
        if (imem_resp_rdy) begin
          pend_req.delete(pick);
          pend_delay.delete(pick);
        end
      end
      // Random stall, never more than two held
      rdy_q      = (pend_req.size() < 2) && ($urandom_range(0, 3) != 0);
      acc_q      = imem_req_val && rdy_q;
      acc_addr_q = imem_req.addr;
      if (acc_q) begin
        pend_req.push_back(imem_req);
        pend_delay.push_back(int'($urandom_range(1, 4)));
      end
    end
  end

endmodule

`default_nettype wire
